// File: dv/mesh_l2_subsys_properties.sv
`timescale 1ns/1ps

module mesh_l2_subsys_properties #(
  parameter int unsigned N_TILES = 3
) (
  input logic               clk,
  input logic               rst_n_i,
  input logic [N_TILES-1:0] tile_cyc_i,
  input logic [N_TILES-1:0] tile_stb_i,
  input logic [N_TILES-1:0] tile_ack_o,
  input logic               eoc_o
);

  int unsigned fail_cnt = 0; // Failed assertions so far

  // One tile served at a time
  a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(tile_ack_o))
    else begin
      fail_cnt++;
      $error("more than one tile_ack_o bit high");
    end

  for (genvar t = 0; t < N_TILES; t++) begin : g_tile
    a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    tile_ack_o[t] |-> (tile_cyc_i[t] && tile_stb_i[t]))
      else begin
        fail_cnt++;
        $error("tile %0d ack without cyc and stb", t);
      end
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
                                  tile_ack_o[t] |=> !tile_ack_o[t]) // Single-cycle ack
      else begin
        fail_cnt++;
        $error("tile %0d ack longer than one cycle", t);
      end
  end

  // Sticky until reset
  a_eoc_sticky: assert property (@(posedge clk) disable iff (!rst_n_i) eoc_o |=> eoc_o)
    else begin
      fail_cnt++;
      $error("eoc_o fell outside reset");
    end

endmodule

// File: dv/mesh_l2_subsys_tb.sv
`timescale 1ns/1ps

module mesh_l2_subsys_tb;
  import mesh_bus_pkg::*;
  import mesh_mbx_pkg::*;

  localparam int unsigned N_TILES    = 3;
  localparam int unsigned L2_WORDS   = 256;
  localparam time         CLK_PERIOD = 40ns;
  localparam int unsigned N_SOLO     = 6; // Full write, partial write, read per step
  localparam int unsigned N_ROUNDS   = 8; // Contended rounds of a write then a read per tile
  localparam int unsigned N_CHARS    = 6;
  localparam int unsigned N_XFERS    = 3*N_TILES*N_SOLO + 2*N_TILES*N_ROUNDS + N_CHARS + 4;
  localparam int unsigned BUDGET     = N_XFERS * N_TILES * 4 + 8; // Cycles including reset
  localparam logic [ADDR_W-1:0] EXIT_ADR = MBX_BASE + 4 * MBX_EXIT_OFS;

  logic                             clk;
  logic                             rst_n_i;
  logic [N_TILES-1:0]               tile_cyc_i;
  logic [N_TILES-1:0]               tile_stb_i;
  logic [N_TILES-1:0]               tile_we_i;
  logic [N_TILES-1:0][ADDR_W-1:0]   tile_adr_i;
  logic [N_TILES-1:0][DATA_W-1:0]   tile_dat_i;
  wb_sel_t [N_TILES-1:0]            tile_sel_i;
  logic [N_TILES-1:0]               tile_ack_o;
  logic [N_TILES-1:0][DATA_W-1:0]   tile_dat_o;
  logic                             stdout_valid_o;
  logic [7:0]                       stdout_char_o;
  logic                             eoc_o;
  logic [15:0]                      exit_errors_o;

  logic [DATA_W-1:0] l2_model [int unsigned]; // Word index to expected contents
  logic [7:0]        char_q [$];               // Characters in issue order
  logic              exp_eoc;
  logic [15:0]       exp_errors;
  logic [31:0]       lfsr_q = 32'h4e9e_b508;
  int unsigned       issued [N_TILES] = '{default: 0};
  int unsigned       acked  [N_TILES] = '{default: 0};

  mesh_l2_subsys #(.N_TILES(N_TILES), .L2_WORDS(L2_WORDS)) i_dut (.*);
  bind mesh_l2_subsys mesh_l2_subsys_properties #(.N_TILES(N_TILES)) i_properties (.*);

  initial begin : clock
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // L2 reference merges the selected bytes of the new word into the old one
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input wb_sel_t           sel);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < $bits(wb_sel_t); b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_char(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: stdout char %h, expected %h", $time, got, exp));
  endtask

  // Magic reads back only once eoc is set
  task automatic check_exit(input mbx_word_u got, input logic [15:0] exp_cnt);
    if (got.ext.magic !== (exp_eoc ? EXIT_MAGIC : 16'h0000) || got.ext.errors !== exp_cnt)
      abort_run($sformatf("mismatch at %0t: exit readback %h, count %h expected",
                          $time, got, exp_cnt));
  endtask

  // One single-beat transfer with the request held until the tile's ack
  task automatic bus_xfer(input int unsigned t, input logic we, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] dat, input wb_sel_t sel);
    @(posedge clk);
    #2ns;
    tile_cyc_i[t] = 1'b1;
    tile_stb_i[t] = 1'b1;
    tile_we_i[t]  = we;
    tile_adr_i[t] = adr;
    tile_dat_i[t] = dat;
    tile_sel_i[t] = sel;
    issued[t]++;
    do @(negedge clk); while (tile_ack_o[t] !== 1'b1);
    @(posedge clk);
    #2ns;
    tile_cyc_i[t] = 1'b0;
    tile_stb_i[t] = 1'b0;
  endtask

  // Mid-cycle compare of every ack with the model updated in ack order
  always @(negedge clk) begin : compare
    logic [ADDR_W-1:0] adr;
    mbx_word_u         wr;
    logic              stdout_exp;
    int unsigned       idx;
    stdout_exp = 1'b0;
    if (i_dut.i_properties.fail_cnt != 0)
      abort_run("a bound assertion on the DUT ports failed");
    if (rst_n_i) begin
      for (int unsigned t = 0; t < N_TILES; t++) begin
        if (tile_ack_o[t] === 1'b1) begin
          acked[t]++;
          adr = tile_adr_i[t];
          wr  = tile_dat_i[t];
          idx = ((adr - L2_BASE) >> 2) % L2_WORDS; // Window wraps at the depth
          if (adr[ADDR_W-1 -: 4] != MBX_BASE[ADDR_W-1 -: 4]) begin
            if (tile_we_i[t])
              l2_model[idx] = merge_bytes(l2_model.exists(idx) ? l2_model[idx] : 'x,
                                          tile_dat_i[t], tile_sel_i[t]);
            else if (!l2_model.exists(idx))
              abort_run($sformatf("tile %0d read L2 word %0d that was never written", t, idx));
            else
              check_word(tile_dat_o[t], l2_model[idx], "L2 read data");
          end else if (adr[2 +: MBX_OFS_W] == MBX_STDOUT_OFS && tile_we_i[t]) begin
            stdout_exp = 1'b1;
            check_char(stdout_char_o, (char_q.size() > 0) ? char_q.pop_front() : 8'hxx);
          end else if (adr[2 +: MBX_OFS_W] == MBX_EXIT_OFS) begin
            if (!tile_we_i[t]) begin
              check_exit(tile_dat_o[t], exp_errors);
            end else if (wr.ext.magic == EXIT_MAGIC) begin // Bad tag changes nothing
              exp_eoc    = 1'b1;
              exp_errors = wr.ext.errors;
            end
          end
        end
      end
      check_word(DATA_W'(stdout_valid_o), DATA_W'(stdout_exp), "stdout_valid_o");
      check_word(DATA_W'(eoc_o), DATA_W'(exp_eoc), "eoc_o");
      check_word(DATA_W'(exit_errors_o), DATA_W'(exp_errors), "exit_errors_o");
    end
  end

  initial begin : watchdog
    #(BUDGET * CLK_PERIOD);
    abort_run($sformatf("timeout: run did not finish within %0d clock cycles", BUDGET));
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] adr [N_SOLO];
    logic [DATA_W-1:0] dat;
    logic              acks_ok;
    {tile_cyc_i, tile_stb_i, tile_we_i, tile_adr_i, tile_dat_i, tile_sel_i} = '0;
    rst_n_i    = 1'b0;
    exp_eoc    = 1'b0;
    exp_errors = '0;
    acks_ok    = 1'b1;
    repeat (3) @(posedge clk);
    #2ns rst_n_i = 1'b1;
    repeat (2) @(negedge clk); // Idle outputs before any request
    if (tile_ack_o !== '0 || stdout_valid_o !== 1'b0 || eoc_o !== 1'b0)
      abort_run("ack, stdout_valid_o or eoc_o not low after reset");
    for (int unsigned t = 0; t < N_TILES; t++) begin
      for (int unsigned i = 0; i < N_SOLO; i++) begin
        adr[i] = ADDR_W'(rand_bits(26)) << 2; // Upper nibble zero so it aliases in L2
        bus_xfer(t, 1'b1, adr[i], rand_bits(32), '1);
      end
      for (int unsigned i = 0; i < N_SOLO; i++) begin
        bus_xfer(t, 1'b1, adr[i], rand_bits(32), wb_sel_t'(rand_bits(4))); // Partial lanes
        bus_xfer(t, 1'b0, adr[i], '0, '1);
      end
    end
    // Early rounds start all tiles together and later ones draw the requesters
    for (int unsigned r = 0; r < N_ROUNDS; r++) begin
      for (int unsigned t = 0; t < N_TILES; t++) begin
        automatic int unsigned       tt = t;
        automatic logic [ADDR_W-1:0] a  = ADDR_W'(rand_bits(26)) << 2;
        automatic logic              go = (r < N_ROUNDS / 2) || rand_bits(1);
        fork
          if (go) begin
            bus_xfer(tt, 1'b1, a, rand_bits(32), '1);
            bus_xfer(tt, 1'b0, a, '0, '1);
          end
        join_none
      end
      wait fork;
    end
    for (int unsigned i = 0; i < N_CHARS; i++) begin
      dat = rand_bits(32); // Reserved bits random too
      char_q.push_back(dat[7:0]);
      bus_xfer(1, 1'b1, MBX_BASE + 4 * MBX_STDOUT_OFS, dat, '1);
    end
    dat = rand_bits(16);
    bus_xfer(2, 1'b1, EXIT_ADR, {EXIT_MAGIC ^ 16'h0100, dat[15:0]}, '1); // Near miss
    bus_xfer(2, 1'b0, EXIT_ADR, '0, '1);
    bus_xfer(2, 1'b1, EXIT_ADR, {EXIT_MAGIC, dat[15:0]}, '1);
    bus_xfer(2, 1'b0, EXIT_ADR, '0, '1);
    repeat (4) @(posedge clk); // eoc has to hold
    for (int unsigned t = 0; t < N_TILES; t++) begin
      acks_ok &= (acked[t] == issued[t]);
    end
    if (acks_ok && i_dut.i_properties.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("ack count differs from request count, or a bound assertion failed");
    end
  end

endmodule

// File: hdl/eoc_mailbox_wb.sv
`timescale 1ns/1ps

module eoc_mailbox_wb (
  input  logic        clk,
  input  logic        rst_n_i,
  wb_if.slave         bus,
  output logic        stdout_valid_o,
  output logic [7:0]  stdout_char_o,
  output logic        eoc_o,
  output logic [15:0] exit_errors_o
);
  import mesh_bus_pkg::*;
  import mesh_mbx_pkg::*;

  logic [ADDR_W-1:0]    word_addr;
  logic [MBX_OFS_W-1:0] ofs;        // Word offset in the page
  mbx_word_u            wr_word;    // Incoming word, two views
  mbx_word_u            rd_word;
  logic                 access;
  logic                 wr_stdout;
  logic                 wr_exit;    // Exit write with good magic
  logic                 ack_q;
  logic                 stdout_valid_q;
  logic [7:0]           char_q;
  logic                 eoc_q;      // Sticky until reset
  logic [15:0]          errors_q;
  logic [DATA_W-1:0]    dat_q;

  assign word_addr = word_index(bus.adr, MBX_BASE);
  assign ofs       = word_addr[MBX_OFS_W-1:0];
  assign wr_word   = bus.dat_w;

  assign access    = bus.cyc & bus.stb & ~ack_q;
  assign wr_stdout = access & bus.we & (ofs == MBX_OFS_W'(MBX_STDOUT_OFS));
  // Wrong magic is acked but dropped
  assign wr_exit   = access & bus.we & (ofs == MBX_OFS_W'(MBX_EXIT_OFS))
                   & (wr_word.ext.magic == EXIT_MAGIC);

  // Readback through the exit view
  assign rd_word.ext = '{magic: (eoc_q ? EXIT_MAGIC : 16'h0000), errors: errors_q};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q          <= 1'b0;
      stdout_valid_q <= 1'b0;
      eoc_q          <= 1'b0;
      errors_q       <= '0;
    end else begin
      ack_q          <= access;
      stdout_valid_q <= wr_stdout; // Lines up with ack
      if (wr_exit) begin
        eoc_q    <= 1'b1;
        errors_q <= wr_word.ext.errors;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_stdout) char_q <= wr_word.chr.ch;
    if (access) dat_q <= rd_word;
  end

  assign bus.ack        = ack_q;
  assign bus.dat_r      = dat_q;
  assign stdout_valid_o = stdout_valid_q;
  assign stdout_char_o  = char_q;
  assign eoc_o          = eoc_q;
  assign exit_errors_o  = errors_q;

endmodule

// File: hdl/l2_sram_wb.sv
`timescale 1ns/1ps

module l2_sram_wb #(
  parameter int unsigned L2_WORDS = 256
) (
  input  logic clk,
  input  logic rst_n_i,
  wb_if.slave  bus
);
  import mesh_bus_pkg::*;

  localparam int unsigned IDX_W = (L2_WORDS > 1) ? $clog2(L2_WORDS) : 1;
  localparam int unsigned N_BYTES = $bits(wb_sel_t);

  logic [DATA_W-1:0] mem [L2_WORDS]; // Shared L2 words
  logic [ADDR_W-1:0] word_addr;
  logic [IDX_W-1:0]  word_idx;
  logic              access;         // First cycle of a transfer
  logic              ack_q;
  logic [DATA_W-1:0] dat_q;

  // Word index wraps modulo the depth
  assign word_addr = word_index(bus.adr, L2_BASE);
  assign word_idx  = IDX_W'(word_addr % L2_WORDS);

  // ack_q masks the held request in the ack cycle
  assign access = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Byte-lane writes with read data captured alongside the ack
  always_ff @(posedge clk) begin
    if (access) begin
      if (bus.we) begin
        for (int unsigned b = 0; b < N_BYTES; b++) begin
          if (bus.sel[b]) mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
        end
      end
      dat_q <= mem[word_idx]; // Old word on a write
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = dat_q;

endmodule

// File: hdl/mesh_bus_pkg.sv
package mesh_bus_pkg;

  // Bus geometry
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // One select bit per data byte
  typedef logic [DATA_W/8-1:0] wb_sel_t;

  // Memory map
  localparam logic [ADDR_W-1:0] L2_BASE  = 32'h0000_0000; // Size set by L2_WORDS
  localparam logic [ADDR_W-1:0] MBX_BASE = 32'h1000_0000; // Mailbox page

  // Width of the region tag compared during decode
  localparam int unsigned REGION_W = 4;

  // Upper nibble equal to the mailbox base selects the mailbox
  // Everything else falls into L2, which wraps modulo its depth
  function automatic logic addr_is_mbx(input logic [ADDR_W-1:0] adr);
    return adr[ADDR_W-1 -: REGION_W] == MBX_BASE[ADDR_W-1 -: REGION_W];
  endfunction

  // Word index of an address relative to a region base
  function automatic logic [ADDR_W-1:0] word_index(input logic [ADDR_W-1:0] adr,
                                                   input logic [ADDR_W-1:0] base);
    return (adr - base) >> 2;
  endfunction

endpackage

// File: hdl/mesh_l2_subsys.sv
`timescale 1ns/1ps

module mesh_l2_subsys #(
  parameter int unsigned N_TILES  = 3,
  parameter int unsigned L2_WORDS = 256
) (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  logic [N_TILES-1:0]                            tile_cyc_i,
  input  logic [N_TILES-1:0]                            tile_stb_i,
  input  logic [N_TILES-1:0]                            tile_we_i,
  input  logic [N_TILES-1:0][mesh_bus_pkg::ADDR_W-1:0]  tile_adr_i,
  input  logic [N_TILES-1:0][mesh_bus_pkg::DATA_W-1:0]  tile_dat_i,
  input  mesh_bus_pkg::wb_sel_t [N_TILES-1:0]           tile_sel_i,
  output logic [N_TILES-1:0]                            tile_ack_o,
  output logic [N_TILES-1:0][mesh_bus_pkg::DATA_W-1:0]  tile_dat_o,
  output logic                                          stdout_valid_o,
  output logic [7:0]                                    stdout_char_o,
  output logic                                          eoc_o,
  output logic [15:0]                                   exit_errors_o
);

  wb_if l2_bus ();  // Interconnect to shared L2
  wb_if mbx_bus (); // Interconnect to mailbox

  mesh_wb_interconnect #(
    .N_TILES (N_TILES)
  ) i_interconnect (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tile_cyc_i (tile_cyc_i),
    .tile_stb_i (tile_stb_i),
    .tile_we_i  (tile_we_i),
    .tile_adr_i (tile_adr_i),
    .tile_dat_i (tile_dat_i),
    .tile_sel_i (tile_sel_i),
    .tile_ack_o (tile_ack_o),
    .tile_dat_o (tile_dat_o),
    .l2_bus     (l2_bus.master),
    .mbx_bus    (mbx_bus.master)
  );

  l2_sram_wb #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (l2_bus.slave)
  );

  eoc_mailbox_wb i_mailbox (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .bus            (mbx_bus.slave),
    .stdout_valid_o (stdout_valid_o),
    .stdout_char_o  (stdout_char_o),
    .eoc_o          (eoc_o),
    .exit_errors_o  (exit_errors_o)
  );

endmodule

// File: hdl/mesh_mbx_pkg.sv
package mesh_mbx_pkg;

  // Word offsets inside the mailbox page
  localparam int unsigned MBX_OFS_W      = 10; // 4 KiB page, word granular
  localparam int unsigned MBX_STDOUT_OFS = 0;  // Character sink
  localparam int unsigned MBX_EXIT_OFS   = 1;  // End of computation

  // Exit writes only count with this tag in the upper half
  localparam logic [15:0] EXIT_MAGIC = 16'hE0C0;

  typedef struct packed {
    logic [23:0] rsvd; // Ignored on write
    logic [7:0]  ch;   // Printed character
  } mbx_char_t;

  typedef struct packed {
    logic [15:0] magic;  // Must equal EXIT_MAGIC
    logic [15:0] errors; // Error count reported by software
  } mbx_exit_t;

  // Same data word, two readings depending on the offset
  typedef union packed {
    mbx_char_t chr;
    mbx_exit_t ext;
  } mbx_word_u;

endpackage

// File: hdl/mesh_wb_interconnect.sv
`timescale 1ns/1ps

module mesh_wb_interconnect #(
  parameter int unsigned N_TILES = 3
) (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  logic [N_TILES-1:0]                            tile_cyc_i,
  input  logic [N_TILES-1:0]                            tile_stb_i,
  input  logic [N_TILES-1:0]                            tile_we_i,
  input  logic [N_TILES-1:0][mesh_bus_pkg::ADDR_W-1:0]  tile_adr_i,
  input  logic [N_TILES-1:0][mesh_bus_pkg::DATA_W-1:0]  tile_dat_i,
  input  mesh_bus_pkg::wb_sel_t [N_TILES-1:0]           tile_sel_i,
  output logic [N_TILES-1:0]                            tile_ack_o,
  output logic [N_TILES-1:0][mesh_bus_pkg::DATA_W-1:0]  tile_dat_o,
  wb_if.master                                          l2_bus,
  wb_if.master                                          mbx_bus
);
  import mesh_bus_pkg::*;

  localparam int unsigned IDX_W = (N_TILES > 1) ? $clog2(N_TILES) : 1;

  logic [N_TILES-1:0] req;          // Tiles with a live request
  logic               grant_valid;  // Some requester found this cycle
  logic [IDX_W-1:0]   grant_idx;    // Round-robin winner
  logic               owner_valid_q;
  logic [IDX_W-1:0]   owner_q;      // Tile currently holding the bus
  logic [IDX_W-1:0]   last_q;       // Previous winner, search starts after it

  logic               own_cyc;
  logic               own_stb;
  logic [ADDR_W-1:0]  own_adr;
  logic               own_is_mbx;   // Decoded target of the owner
  logic               slv_ack;
  logic [DATA_W-1:0]  slv_dat;

  assign req = tile_cyc_i & tile_stb_i;

  // Lowest-numbered requester after the last winner
  always_comb begin
    int unsigned cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int unsigned i = 1; i <= N_TILES; i++) begin
      cand = last_q + i;
      if (cand >= N_TILES) cand = cand - N_TILES; // Wrap around
      if (!grant_valid && req[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = IDX_W'(cand);
      end
    end
  end

  // Grant is only taken when the bus is free
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      owner_valid_q <= 1'b0;
      owner_q       <= '0;
      last_q        <= IDX_W'(N_TILES - 1); // Tile 0 goes first
    end else if (!owner_valid_q) begin
      if (grant_valid) begin
        owner_valid_q <= 1'b1;
        owner_q       <= grant_idx;
        last_q        <= grant_idx;
      end
    end else if (slv_ack) begin
      owner_valid_q <= 1'b0; // Released in the ack cycle
    end
  end

  // Owner's request fields
  assign own_cyc    = owner_valid_q & tile_cyc_i[owner_q];
  assign own_stb    = owner_valid_q & tile_stb_i[owner_q];
  assign own_adr    = tile_adr_i[owner_q];
  assign own_is_mbx = addr_is_mbx(own_adr);

  // Only the decoded slave sees cyc and stb
  assign l2_bus.cyc   = own_cyc & ~own_is_mbx;
  assign l2_bus.stb   = own_stb & ~own_is_mbx;
  assign l2_bus.we    = tile_we_i[owner_q];
  assign l2_bus.adr   = own_adr;
  assign l2_bus.dat_w = tile_dat_i[owner_q];
  assign l2_bus.sel   = tile_sel_i[owner_q];

  assign mbx_bus.cyc   = own_cyc & own_is_mbx;
  assign mbx_bus.stb   = own_stb & own_is_mbx;
  assign mbx_bus.we    = tile_we_i[owner_q];
  assign mbx_bus.adr   = own_adr;
  assign mbx_bus.dat_w = tile_dat_i[owner_q];
  assign mbx_bus.sel   = tile_sel_i[owner_q];

  // Response from whichever slave was addressed
  assign slv_ack = owner_valid_q & (own_is_mbx ? mbx_bus.ack : l2_bus.ack);
  assign slv_dat = own_is_mbx ? mbx_bus.dat_r : l2_bus.dat_r;

  // Ack and data go back to the owner alone
  always_comb begin
    tile_ack_o = '0;
    tile_dat_o = '0;
    if (owner_valid_q) begin
      tile_ack_o[owner_q] = slv_ack;
      tile_dat_o[owner_q] = slv_dat;
    end
  end

endmodule

// File: hdl/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
  import mesh_bus_pkg::*;

  // Request side
  logic              cyc;
  logic              stb;
  logic              we;
  logic [ADDR_W-1:0] adr;   // Byte address
  logic [DATA_W-1:0] dat_w;
  wb_sel_t           sel;   // Byte lanes

  // Response side
  logic [DATA_W-1:0] dat_r; // Valid with ack
  logic              ack;   // Single cycle pulse

  // Initiator holds the request until ack
  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  // Target answers with a registered ack
  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

// File: mesh_l2_subsys.f
hdl/mesh_bus_pkg.sv
hdl/mesh_mbx_pkg.sv
hdl/wb_if.sv
hdl/mesh_wb_interconnect.sv
hdl/l2_sram_wb.sv
hdl/eoc_mailbox_wb.sv
hdl/mesh_l2_subsys.sv
dv/mesh_l2_subsys_properties.sv
dv/mesh_l2_subsys_tb.sv
